// ==== filelist.f ====
bus_pkg.sv
clint_timer.sv
read_router.sv
bus_arbiter.sv
core_bus_top.sv
tb_mem_model.sv
tb_core_bus.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_core_bus \
  -f filelist.f -o tb_core_bus \
  && ./obj_dir/tb_core_bus > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

// ==== tb_core_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_bus;

  localparam int k_fetch     = 0;
  localparam int k_lsu_rd    = 1;
  localparam int k_lsu_wr    = 2;
  localparam int k_both      = 3;  // lsu at addr, fetch at addr + 'h100
  localparam int k_stall     = 4;  // k_both with lsu rready held low
  localparam int k_mtime_inc = 5;  // low word must exceed the previous read
  localparam logic [31:0] exp_okay   = {30'd0, bus_pkg::resp_okay};
  localparam logic [31:0] exp_slverr = {30'd0, bus_pkg::resp_slverr};
  localparam logic [2:0]  lsu_rd_size = 3'b001;  // lsu reads are halfword, fetch stays word

  logic clock, reset;
  logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
  logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
  logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
  logic [31:0] fetch_araddr, fetch_rdata, lsu_araddr, lsu_rdata, lsu_awaddr, lsu_wdata;
  logic [2:0] lsu_arsize, lsu_awsize;
  logic [3:0] lsu_wstrb;
  logic [1:0] fetch_rresp, lsu_rresp, lsu_bresp;
  logic io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
  logic io_master_wlast, io_master_bready, io_master_bvalid;
  logic io_master_arready, io_master_arvalid, io_master_rready, io_master_rvalid;
  logic [31:0] io_master_awaddr, io_master_wdata, io_master_araddr, io_master_rdata;
  logic [3:0] io_master_awid, io_master_wstrb, io_master_arid, io_master_rid;
  logic [7:0] io_master_awlen, io_master_arlen;
  logic [2:0] io_master_awsize, io_master_arsize;
  logic [1:0] io_master_awburst, io_master_arburst, io_master_bresp, io_master_rresp;

  string       ent_name[$];
  int          ent_kind[$];
  logic [31:0] ent_addr[$], ent_wdata[$], ent_exp[$], ent_resp[$];
  logic [3:0]  ent_strb[$];
  logic        entries_ready = 1'b0;
  int          errors = 0;
  logic [31:0] ext_ar_cycles = '0;  // cycles with io_master_arvalid high

  core_bus_top u_dut (.*);
  tb_mem_model u_mem (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    if (io_master_arvalid)
      ext_ar_cycles <= ext_ar_cycles + 32'd1;
  end

  function automatic logic [31:0] ext_data(input logic [31:0] addr);
    return addr ^ 32'hc0de_0000;
  endfunction

  function automatic logic in_clint(input logic [31:0] addr);
    return addr >= bus_pkg::clint_base && addr < bus_pkg::clint_base + bus_pkg::clint_size;
  endfunction

  task automatic add_entry(input string name, input int kind, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic [31:0] exp, input logic [31:0] resp);
    ent_name.push_back(name);
    ent_kind.push_back(kind);
    ent_addr.push_back(addr);
    ent_wdata.push_back(wdata);
    ent_strb.push_back(strb);
    ent_exp.push_back(exp);
    ent_resp.push_back(resp);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic write_lsu(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           output logic [1:0] resp);
    logic aw_fire, w_fire, b_done;
    b_done = 1'b0;
    @(negedge clock);
    lsu_awvalid = 1'b1;
    lsu_awaddr  = addr;
    lsu_awsize  = (strb == 4'hf) ? bus_pkg::size_word :
                  (strb == 4'h3 || strb == 4'hc) ? 3'b001 : 3'b000;
    lsu_wvalid  = 1'b1;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    lsu_bready  = 1'b1;
    while (!b_done) begin
      @(posedge clock);
      aw_fire = lsu_awvalid && lsu_awready;
      w_fire  = lsu_wvalid && lsu_wready;
      if (aw_fire) begin
        compare_value({name, " awid"}, {28'd0, bus_pkg::lsu_id}, {28'd0, io_master_awid});
        compare_value({name, " awlen"}, 32'd0, {24'd0, io_master_awlen});
        compare_value({name, " awsize"}, {29'd0, lsu_awsize}, {29'd0, io_master_awsize});
        compare_value({name, " awburst"}, {30'd0, bus_pkg::burst_incr},
                      {30'd0, io_master_awburst});
      end
      if (w_fire)
        compare_value({name, " wlast"}, 32'd1, {31'd0, io_master_wlast});
      if (lsu_bvalid && lsu_bready) begin
        b_done = 1'b1;
        resp   = lsu_bresp;
      end
      @(negedge clock);
      if (aw_fire)
        lsu_awvalid = 1'b0;
      if (w_fire)
        lsu_wvalid = 1'b0;
    end
    lsu_bready = 1'b0;
  endtask

  // one read on either port or both at once, optional stall on the lsu side
  task automatic read_ports(input string name, input logic use_lsu, input logic use_fetch,
                            input logic [31:0] l_addr, input logic [31:0] f_addr,
                            input int stall, output logic [31:0] l_data, l_resp,
                            output logic [31:0] f_data, f_resp, output logic lsu_first);
    logic        l_done, f_done, l_ar, f_ar, held;
    logic [31:0] held_data;
    int          stalled;
    l_done    = !use_lsu;
    f_done    = !use_fetch;
    held      = 1'b0;
    stalled   = 0;
    lsu_first = 1'b0;
    @(negedge clock);
    lsu_arvalid   = use_lsu;
    lsu_araddr    = l_addr;
    lsu_arsize    = lsu_rd_size;
    lsu_rready    = (stall == 0);
    fetch_arvalid = use_fetch;
    fetch_araddr  = f_addr;
    fetch_rready  = 1'b1;
    while (!(l_done && f_done)) begin
      @(posedge clock);
      l_ar = lsu_arvalid && lsu_arready;
      f_ar = fetch_arvalid && fetch_arready;
      if (io_master_arvalid && io_master_arready) begin
        compare_value({name, " arid"},
                      l_ar ? {28'd0, bus_pkg::lsu_id} : {28'd0, bus_pkg::fetch_id},
                      {28'd0, io_master_arid});
        compare_value({name, " arsize"},
                      l_ar ? {29'd0, lsu_rd_size} : {29'd0, bus_pkg::size_word},
                      {29'd0, io_master_arsize});
        compare_value({name, " arlen"}, 32'd0, {24'd0, io_master_arlen});
        compare_value({name, " arburst"}, {30'd0, bus_pkg::burst_incr},
                      {30'd0, io_master_arburst});
      end
      if (held && !lsu_rready) begin
        compare_value({name, " rvalid held"}, 32'd1, {31'd0, lsu_rvalid});
        compare_value({name, " rdata held"}, held_data, lsu_rdata);
        compare_value({name, " no new grant"}, 32'd0, {31'd0, fetch_arready});
        compare_value({name, " no ext ar"}, 32'd0, {31'd0, io_master_arvalid});
      end
      if (lsu_rvalid && !held) begin
        held      = 1'b1;
        held_data = lsu_rdata;
      end
      if (lsu_rvalid && lsu_rready) begin
        l_done = 1'b1;
        l_data = lsu_rdata;
        l_resp = {30'd0, lsu_rresp};
      end
      if (fetch_rvalid && fetch_rready) begin
        f_done    = 1'b1;
        lsu_first = l_done;  // was lsu served already
        f_data    = fetch_rdata;
        f_resp    = {30'd0, fetch_rresp};
      end
      @(negedge clock);
      if (l_ar)
        lsu_arvalid = 1'b0;
      if (f_ar)
        fetch_arvalid = 1'b0;
      if (held && !lsu_rready) begin
        stalled++;
        if (stalled >= stall)
          lsu_rready = 1'b1;
      end
    end
    lsu_rready   = 1'b0;
    fetch_rready = 1'b0;
  endtask

  initial begin : watchdog
    wait (entries_ready);
    repeat (200 * ent_name.size()) @(posedge clock);
    $display("run timed out, the DUT stopped answering");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] l_data, l_resp, f_data, f_resp, rd_data, rd_resp, ext_before;
    logic [31:0] last_lo;
    logic [1:0]  w_resp;
    logic        lsu_first, is_fetch;
    reset         = 1'b1;
    fetch_arvalid = 1'b0;
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    lsu_arvalid   = 1'b0;
    lsu_araddr    = '0;
    lsu_arsize    = bus_pkg::size_word;
    lsu_rready    = 1'b0;
    lsu_awvalid   = 1'b0;
    lsu_awaddr    = '0;
    lsu_awsize    = bus_pkg::size_word;
    lsu_wvalid    = 1'b0;
    lsu_wdata     = '0;
    lsu_wstrb     = '0;
    lsu_bready    = 1'b0;
    last_lo       = '0;
    add_entry("fetch_ext", k_fetch, 32'h8000_0000, 0, 0, ext_data(32'h8000_0000), exp_okay);
    add_entry("fetch_ext2", k_fetch, 32'h8000_1230, 0, 0, ext_data(32'h8000_1230), exp_okay);
    add_entry("lsu_rd_ext", k_lsu_rd, 32'h8000_0040, 0, 0, ext_data(32'h8000_0040), exp_okay);
    add_entry("lsu_rd_ext2", k_lsu_rd, 32'h3000_0ffc, 0, 0, ext_data(32'h3000_0ffc), exp_okay);
    add_entry("both_ports", k_both, 32'h8000_0200, 0, 0, ext_data(32'h8000_0200), exp_okay);
    add_entry("mtime_hi", k_lsu_rd, 32'h0200_bffc, 0, 0, 32'd0, exp_okay);
    add_entry("mtime_lo_a", k_mtime_inc, 32'h0200_bff8, 0, 0, 32'd0, exp_okay);
    add_entry("mtime_lo_b", k_mtime_inc, 32'h0200_bff8, 0, 0, 32'd0, exp_okay);
    add_entry("clint_unmapped", k_lsu_rd, 32'h0200_0004, 0, 0, 32'd0, exp_slverr);
    add_entry("fetch_clint_hole", k_fetch, 32'h0200_4000, 0, 0, 32'd0, exp_slverr);
    add_entry("lsu_wr_word", k_lsu_wr, 32'h8000_0100, 32'hdead_beef, 4'hf, 0, exp_okay);
    add_entry("lsu_wr_byte", k_lsu_wr, 32'h8000_0103, 32'h1122_3344, 4'h8, 0, exp_okay);
    add_entry("lsu_wr_clint", k_lsu_wr, 32'h0200_bff8, 32'h5a5a_0f0f, 4'h3, 0, exp_okay);
    add_entry("rready_stall", k_stall, 32'h8000_0400, 0, 0, ext_data(32'h8000_0400), exp_okay);
    entries_ready = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < ent_name.size(); i++) begin
      case (ent_kind[i])
        k_lsu_wr: begin
          write_lsu(ent_name[i], ent_addr[i], ent_wdata[i], ent_strb[i], w_resp);
          compare_value({ent_name[i], " bresp"}, ent_resp[i], {30'd0, w_resp});
          compare_value({ent_name[i], " addr"}, ent_addr[i], u_mem.last_awaddr);
          compare_value({ent_name[i], " data"}, ent_wdata[i], u_mem.last_wdata);
          compare_value({ent_name[i], " strb"}, {28'd0, ent_strb[i]}, {28'd0, u_mem.last_wstrb});
        end
        k_both, k_stall: begin
          read_ports(ent_name[i], 1'b1, 1'b1, ent_addr[i], ent_addr[i] + 32'h100,
                     (ent_kind[i] == k_stall) ? 4 : 0, l_data, l_resp, f_data, f_resp,
                     lsu_first);
          compare_value({ent_name[i], " lsu data"}, ent_exp[i], l_data);
          compare_value({ent_name[i], " lsu resp"}, ent_resp[i], l_resp);
          compare_value({ent_name[i], " fetch data"}, ext_data(ent_addr[i] + 32'h100), f_data);
          compare_value({ent_name[i], " fetch resp"}, exp_okay, f_resp);
          compare_value({ent_name[i], " lsu first"}, 32'd1, {31'd0, lsu_first});
        end
        default: begin
          ext_before = ext_ar_cycles;
          is_fetch   = (ent_kind[i] == k_fetch);
          read_ports(ent_name[i], !is_fetch, is_fetch, ent_addr[i], ent_addr[i], 0,
                     l_data, l_resp, f_data, f_resp, lsu_first);
          rd_data = is_fetch ? f_data : l_data;
          rd_resp = is_fetch ? f_resp : l_resp;
          if (ent_kind[i] == k_mtime_inc) begin
            compare_value({ent_name[i], " increasing"}, 32'd1, {31'd0, rd_data > last_lo});
            last_lo = rd_data;
          end else
            compare_value({ent_name[i], " data"}, ent_exp[i], rd_data);
          compare_value({ent_name[i], " resp"}, ent_resp[i], rd_resp);
          if (in_clint(ent_addr[i]))
            compare_value({ent_name[i], " ext ar"}, 32'd0, ext_ar_cycles - ext_before);
        end
      endcase
    end
    $display("%0d entries run, %0d errors", ent_name.size(), errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire         clock,
  input  wire         reset,
  input  wire         io_master_arvalid,
  output logic        io_master_arready,
  input  wire  [31:0] io_master_araddr,
  input  wire  [3:0]  io_master_arid,
  output logic        io_master_rvalid,
  input  wire         io_master_rready,
  output logic [31:0] io_master_rdata,
  output logic [1:0]  io_master_rresp,
  output logic [3:0]  io_master_rid,
  input  wire         io_master_awvalid,
  output logic        io_master_awready,
  input  wire  [31:0] io_master_awaddr,
  input  wire         io_master_wvalid,
  output logic        io_master_wready,
  input  wire  [31:0] io_master_wdata,
  input  wire  [3:0]  io_master_wstrb,
  output logic        io_master_bvalid,
  input  wire         io_master_bready,
  output logic [1:0]  io_master_bresp
);

  integer      seed = 32'h9143_860f;
  logic [31:0] rnd;
  logic [1:0]  wait_cnt;
  logic        pending;
  logic        got_aw;
  logic        got_w;
  logic [31:0] rd_addr;
  logic [3:0]  rd_id;
  logic [31:0] last_awaddr;   // last accepted write, read by the testbench
  logic [31:0] last_wdata;
  logic [3:0]  last_wstrb;
  logic        ar_fire_q = 1'b0;
  logic        r_fire_q  = 1'b0;
  logic        aw_fire_q = 1'b0;
  logic        w_fire_q  = 1'b0;
  logic        b_fire_q  = 1'b0;

  // bus idle until the first falling edge
  initial begin
    io_master_arready = 1'b0;
    io_master_rvalid  = 1'b0;
    io_master_rdata   = '0;
    io_master_rresp   = bus_pkg::resp_okay;
    io_master_rid     = '0;
    io_master_awready = 1'b0;
    io_master_wready  = 1'b0;
    io_master_bvalid  = 1'b0;
    io_master_bresp   = bus_pkg::resp_okay;
  end

  // handshakes seen at the rising edge
  always @(posedge clock) begin
    ar_fire_q <= io_master_arvalid && io_master_arready;
    r_fire_q  <= io_master_rvalid && io_master_rready;
    aw_fire_q <= io_master_awvalid && io_master_awready;
    w_fire_q  <= io_master_wvalid && io_master_wready;
    b_fire_q  <= io_master_bvalid && io_master_bready;
    if (io_master_arvalid && io_master_arready) begin
      rd_addr <= io_master_araddr;
      rd_id   <= io_master_arid;
    end
    if (io_master_awvalid && io_master_awready)
      last_awaddr <= io_master_awaddr;
    if (io_master_wvalid && io_master_wready) begin
      last_wdata <= io_master_wdata;
      last_wstrb <= io_master_wstrb;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clock) begin
    if (reset) begin
      io_master_arready = 1'b0;
      io_master_rvalid  = 1'b0;
      io_master_awready = 1'b0;
      io_master_wready  = 1'b0;
      io_master_bvalid  = 1'b0;
      pending = 1'b0;
      got_aw  = 1'b0;
      got_w   = 1'b0;
    end else begin
      if (ar_fire_q) begin
        rnd      = $random(seed);
        wait_cnt = rnd[1:0];  // 0 to 3 cycles
        pending  = 1'b1;
      end
      if (r_fire_q)
        io_master_rvalid = 1'b0;
      if (pending && wait_cnt != 2'd0)
        wait_cnt = wait_cnt - 2'd1;
      else if (pending) begin
        io_master_rvalid = 1'b1;
        io_master_rdata  = rd_addr ^ 32'hc0de_0000;
        io_master_rresp  = bus_pkg::resp_okay;
        io_master_rid    = rd_id;
        pending          = 1'b0;
      end
      io_master_arready = !pending && !io_master_rvalid;
      if (aw_fire_q)
        got_aw = 1'b1;
      if (w_fire_q)
        got_w = 1'b1;
      if (b_fire_q)
        io_master_bvalid = 1'b0;
      if (got_aw && got_w && !io_master_bvalid) begin
        io_master_bvalid = 1'b1;   // both halves in, answer
        io_master_bresp  = bus_pkg::resp_okay;
        got_aw = 1'b0;
        got_w  = 1'b0;
      end
      io_master_awready = !got_aw && !io_master_bvalid;
      io_master_wready  = !got_w && !io_master_bvalid;
    end
  end

endmodule

`default_nettype wire

// ==== core_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_bus_top (
  input  wire                         clock,
  input  wire                         reset,

  // fetch read port
  input  wire                         fetch_arvalid,
  output logic                        fetch_arready,
  input  wire  [bus_pkg::addr_w-1:0]  fetch_araddr,
  output logic                        fetch_rvalid,
  input  wire                         fetch_rready,
  output logic [bus_pkg::data_w-1:0]  fetch_rdata,
  output logic [1:0]                  fetch_rresp,

  // load/store read port
  input  wire                         lsu_arvalid,
  output logic                        lsu_arready,
  input  wire  [bus_pkg::addr_w-1:0]  lsu_araddr,
  input  wire  [2:0]                  lsu_arsize,
  output logic                        lsu_rvalid,
  input  wire                         lsu_rready,
  output logic [bus_pkg::data_w-1:0]  lsu_rdata,
  output logic [1:0]                  lsu_rresp,

  // load/store write port
  input  wire                         lsu_awvalid,
  output logic                        lsu_awready,
  input  wire  [bus_pkg::addr_w-1:0]  lsu_awaddr,
  input  wire  [2:0]                  lsu_awsize,
  input  wire                         lsu_wvalid,
  output logic                        lsu_wready,
  input  wire  [bus_pkg::data_w-1:0]  lsu_wdata,
  input  wire  [3:0]                  lsu_wstrb,
  output logic                        lsu_bvalid,
  input  wire                         lsu_bready,
  output logic [1:0]                  lsu_bresp,

  // external AXI4 master
  input  wire                         io_master_awready,
  output logic                        io_master_awvalid,
  output logic [bus_pkg::addr_w-1:0]  io_master_awaddr,
  output logic [bus_pkg::id_w-1:0]    io_master_awid,
  output logic [7:0]                  io_master_awlen,
  output logic [2:0]                  io_master_awsize,
  output logic [1:0]                  io_master_awburst,
  input  wire                         io_master_wready,
  output logic                        io_master_wvalid,
  output logic [bus_pkg::data_w-1:0]  io_master_wdata,
  output logic [3:0]                  io_master_wstrb,
  output logic                        io_master_wlast,
  output logic                        io_master_bready,
  input  wire                         io_master_bvalid,
  input  wire  [1:0]                  io_master_bresp,
  input  wire                         io_master_arready,
  output logic                        io_master_arvalid,
  output logic [bus_pkg::addr_w-1:0]  io_master_araddr,
  output logic [bus_pkg::id_w-1:0]    io_master_arid,
  output logic [7:0]                  io_master_arlen,
  output logic [2:0]                  io_master_arsize,
  output logic [1:0]                  io_master_arburst,
  output logic                        io_master_rready,
  input  wire                         io_master_rvalid,
  input  wire  [1:0]                  io_master_rresp,
  input  wire  [bus_pkg::data_w-1:0]  io_master_rdata,
  input  wire  [bus_pkg::id_w-1:0]    io_master_rid
);

  // granted read channel, arbiter to router
  logic                        gnt_arvalid;
  logic                        gnt_arready;
  logic [bus_pkg::addr_w-1:0]  gnt_araddr;
  logic [bus_pkg::id_w-1:0]    gnt_arid;
  logic [2:0]                  gnt_arsize;
  logic                        gnt_rvalid;
  logic                        gnt_rready;
  logic [bus_pkg::data_w-1:0]  gnt_rdata;
  logic [1:0]                  gnt_rresp;
  logic [bus_pkg::id_w-1:0]    gnt_rid;

  // router to timer
  logic                        clint_arvalid;
  logic                        clint_arready;
  logic [bus_pkg::addr_w-1:0]  clint_araddr;
  logic [bus_pkg::id_w-1:0]    clint_arid;
  logic                        clint_rvalid;
  logic                        clint_rready;
  logic [bus_pkg::data_w-1:0]  clint_rdata;
  logic [1:0]                  clint_rresp;
  logic [bus_pkg::id_w-1:0]    clint_rid;

  // writes bypass the read path entirely
  assign io_master_awvalid = lsu_awvalid;
  assign io_master_awaddr  = lsu_awaddr;
  assign io_master_awid    = bus_pkg::lsu_id;
  assign io_master_awlen   = 8'd0;               // single beat
  assign io_master_awsize  = lsu_awsize;
  assign io_master_awburst = bus_pkg::burst_incr;
  assign lsu_awready       = io_master_awready;
  assign io_master_wvalid  = lsu_wvalid;
  assign io_master_wdata   = lsu_wdata;
  assign io_master_wstrb   = lsu_wstrb;
  assign io_master_wlast   = 1'b1;
  assign lsu_wready        = io_master_wready;
  assign lsu_bvalid        = io_master_bvalid;
  assign lsu_bresp         = io_master_bresp;
  assign io_master_bready  = lsu_bready;

  assign io_master_arlen   = 8'd0;
  assign io_master_arburst = bus_pkg::burst_incr;

  bus_arbiter u_arbiter (
    .clock(clock), .reset(reset),
    .fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
    .fetch_araddr(fetch_araddr),
    .fetch_rvalid(fetch_rvalid), .fetch_rready(fetch_rready),
    .fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
    .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
    .lsu_araddr(lsu_araddr), .lsu_arsize(lsu_arsize),
    .lsu_rvalid(lsu_rvalid), .lsu_rready(lsu_rready),
    .lsu_rdata(lsu_rdata), .lsu_rresp(lsu_rresp),
    .gnt_arvalid(gnt_arvalid), .gnt_arready(gnt_arready),
    .gnt_araddr(gnt_araddr), .gnt_arid(gnt_arid), .gnt_arsize(gnt_arsize),
    .gnt_rvalid(gnt_rvalid), .gnt_rready(gnt_rready),
    .gnt_rdata(gnt_rdata), .gnt_rresp(gnt_rresp), .gnt_rid(gnt_rid)
  );

  read_router u_router (
    .clock(clock), .reset(reset),
    .gnt_arvalid(gnt_arvalid), .gnt_arready(gnt_arready),
    .gnt_araddr(gnt_araddr), .gnt_arid(gnt_arid), .gnt_arsize(gnt_arsize),
    .gnt_rvalid(gnt_rvalid), .gnt_rready(gnt_rready),
    .gnt_rdata(gnt_rdata), .gnt_rresp(gnt_rresp), .gnt_rid(gnt_rid),
    .clint_arvalid(clint_arvalid), .clint_arready(clint_arready),
    .clint_araddr(clint_araddr), .clint_arid(clint_arid),
    .clint_rvalid(clint_rvalid), .clint_rready(clint_rready),
    .clint_rdata(clint_rdata), .clint_rresp(clint_rresp), .clint_rid(clint_rid),
    .io_master_arvalid(io_master_arvalid), .io_master_arready(io_master_arready),
    .io_master_araddr(io_master_araddr), .io_master_arid(io_master_arid),
    .io_master_arsize(io_master_arsize),
    .io_master_rvalid(io_master_rvalid), .io_master_rready(io_master_rready),
    .io_master_rdata(io_master_rdata), .io_master_rresp(io_master_rresp),
    .io_master_rid(io_master_rid)
  );

  clint_timer u_clint (
    .clock(clock), .reset(reset),
    .clint_arvalid(clint_arvalid), .clint_arready(clint_arready),
    .clint_araddr(clint_araddr), .clint_arid(clint_arid),
    .clint_rvalid(clint_rvalid), .clint_rready(clint_rready),
    .clint_rdata(clint_rdata), .clint_rresp(clint_rresp), .clint_rid(clint_rid)
  );

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire                         clock,
  input  wire                         reset,

  // fetch requester, always word sized
  input  wire                         fetch_arvalid,
  output logic                        fetch_arready,
  input  wire  [bus_pkg::addr_w-1:0]  fetch_araddr,
  output logic                        fetch_rvalid,
  input  wire                         fetch_rready,
  output logic [bus_pkg::data_w-1:0]  fetch_rdata,
  output logic [1:0]                  fetch_rresp,

  // load/store requester
  input  wire                         lsu_arvalid,
  output logic                        lsu_arready,
  input  wire  [bus_pkg::addr_w-1:0]  lsu_araddr,
  input  wire  [2:0]                  lsu_arsize,
  output logic                        lsu_rvalid,
  input  wire                         lsu_rready,
  output logic [bus_pkg::data_w-1:0]  lsu_rdata,
  output logic [1:0]                  lsu_rresp,

  // granted channel toward the router
  output logic                        gnt_arvalid,
  input  wire                         gnt_arready,
  output logic [bus_pkg::addr_w-1:0]  gnt_araddr,
  output logic [bus_pkg::id_w-1:0]    gnt_arid,
  output logic [2:0]                  gnt_arsize,
  input  wire                         gnt_rvalid,
  output logic                        gnt_rready,
  input  wire  [bus_pkg::data_w-1:0]  gnt_rdata,
  input  wire  [1:0]                  gnt_rresp,
  input  wire  [bus_pkg::id_w-1:0]    gnt_rid
);

  logic                      busy;       // a read is outstanding
  logic [bus_pkg::id_w-1:0]  owner_id;   // id of the request in flight
  logic                      sel_lsu;
  logic                      owner_lsu;
  logic                      id_match;
  logic                      ar_fire;
  logic                      r_fire;

  // load/store wins over fetch when both ask in the same cycle
  assign sel_lsu = lsu_arvalid;

  assign gnt_arvalid = !busy && (lsu_arvalid || fetch_arvalid);
  assign gnt_araddr  = sel_lsu ? lsu_araddr : fetch_araddr;
  assign gnt_arid    = sel_lsu ? bus_pkg::lsu_id : bus_pkg::fetch_id;
  assign gnt_arsize  = sel_lsu ? lsu_arsize : bus_pkg::size_word;

  // loser sees arready low until the winner's response is taken
  assign lsu_arready   = !busy && lsu_arvalid && gnt_arready;
  assign fetch_arready = !busy && !lsu_arvalid && fetch_arvalid && gnt_arready;

  assign ar_fire = gnt_arvalid && gnt_arready;

  // response goes to the recorded owner, never to a live requester
  assign owner_lsu = (owner_id == bus_pkg::lsu_id);
  assign id_match  = busy && (gnt_rid == owner_id);  // stray ids are held off

  assign lsu_rvalid   = gnt_rvalid && id_match && owner_lsu;
  assign fetch_rvalid = gnt_rvalid && id_match && !owner_lsu;
  assign lsu_rdata    = gnt_rdata;
  assign lsu_rresp    = gnt_rresp;
  assign fetch_rdata  = gnt_rdata;
  assign fetch_rresp  = gnt_rresp;

  assign gnt_rready = id_match && (owner_lsu ? lsu_rready : fetch_rready);
  assign r_fire     = gnt_rvalid && gnt_rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      owner_id <= bus_pkg::fetch_id;
    end else if (ar_fire) begin
      busy     <= 1'b1;
      owner_id <= gnt_arid;
    end else if (r_fire) begin
      busy <= 1'b0;  // next grant one cycle later
    end
  end

endmodule

`default_nettype wire

// ==== read_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_router (
  input  wire                         clock,
  input  wire                         reset,

  // from the arbiter
  input  wire                         gnt_arvalid,
  output logic                        gnt_arready,
  input  wire  [bus_pkg::addr_w-1:0]  gnt_araddr,
  input  wire  [bus_pkg::id_w-1:0]    gnt_arid,
  input  wire  [2:0]                  gnt_arsize,
  output logic                        gnt_rvalid,
  input  wire                         gnt_rready,
  output logic [bus_pkg::data_w-1:0]  gnt_rdata,
  output logic [1:0]                  gnt_rresp,
  output logic [bus_pkg::id_w-1:0]    gnt_rid,

  // internal timer
  output logic                        clint_arvalid,
  input  wire                         clint_arready,
  output logic [bus_pkg::addr_w-1:0]  clint_araddr,
  output logic [bus_pkg::id_w-1:0]    clint_arid,
  input  wire                         clint_rvalid,
  output logic                        clint_rready,
  input  wire  [bus_pkg::data_w-1:0]  clint_rdata,
  input  wire  [1:0]                  clint_rresp,
  input  wire  [bus_pkg::id_w-1:0]    clint_rid,

  // external AXI4 read channels
  output logic                        io_master_arvalid,
  input  wire                         io_master_arready,
  output logic [bus_pkg::addr_w-1:0]  io_master_araddr,
  output logic [bus_pkg::id_w-1:0]    io_master_arid,
  output logic [2:0]                  io_master_arsize,
  input  wire                         io_master_rvalid,
  output logic                        io_master_rready,
  input  wire  [bus_pkg::data_w-1:0]  io_master_rdata,
  input  wire  [1:0]                  io_master_rresp,
  input  wire  [bus_pkg::id_w-1:0]    io_master_rid
);

  logic in_window;   // live decode of the request address
  logic tgt_clint;   // target of the read in flight

  assign in_window = (gnt_araddr >= bus_pkg::clint_base) &&
                     (gnt_araddr <  bus_pkg::clint_base + bus_pkg::clint_size);

  assign clint_arvalid = gnt_arvalid && in_window;
  assign clint_araddr  = gnt_araddr;
  assign clint_arid    = gnt_arid;

  assign io_master_arvalid = gnt_arvalid && !in_window;
  assign io_master_araddr  = gnt_araddr;
  assign io_master_arid    = gnt_arid;
  assign io_master_arsize  = gnt_arsize;

  assign gnt_arready = in_window ? clint_arready : io_master_arready;

  // the R mux follows the latched target, the address may have moved on
  always_ff @(posedge clock) begin
    if (reset)
      tgt_clint <= 1'b0;
    else if (gnt_arvalid && gnt_arready)
      tgt_clint <= in_window;
  end

  assign gnt_rvalid = tgt_clint ? clint_rvalid : io_master_rvalid;
  assign gnt_rdata  = tgt_clint ? clint_rdata  : io_master_rdata;
  assign gnt_rresp  = tgt_clint ? clint_rresp  : io_master_rresp;
  assign gnt_rid    = tgt_clint ? clint_rid    : io_master_rid;

  assign clint_rready     = tgt_clint && gnt_rready;
  assign io_master_rready = !tgt_clint && gnt_rready;

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  wire                         clock,
  input  wire                         reset,

  // read-only AXI4 slave, single beat
  input  wire                         clint_arvalid,
  output logic                        clint_arready,
  input  wire  [bus_pkg::addr_w-1:0]  clint_araddr,
  input  wire  [bus_pkg::id_w-1:0]    clint_arid,
  output logic                        clint_rvalid,
  input  wire                         clint_rready,
  output logic [bus_pkg::data_w-1:0]  clint_rdata,
  output logic [1:0]                  clint_rresp,
  output logic [bus_pkg::id_w-1:0]    clint_rid
);

  bus_pkg::mtime_t mtime;
  logic            ar_fire;
  logic            r_fire;
  logic [15:0]     offset;   // only the low half selects a register

  assign ar_fire = clint_arvalid && clint_arready;
  assign r_fire  = clint_rvalid && clint_rready;
  assign offset  = clint_araddr[15:0];

  // free-running machine timer
  always_ff @(posedge clock) begin
    if (reset)
      mtime.count <= '0;
    else
      mtime.count <= mtime.count + 1'b1;
  end

  // arready comes up one cycle out of reset, drops while a response is pending
  always_ff @(posedge clock) begin
    if (reset) begin
      clint_arready <= 1'b0;
      clint_rvalid  <= 1'b0;
    end else if (ar_fire) begin
      clint_arready <= 1'b0;
      clint_rvalid  <= 1'b1;
    end else if (r_fire) begin
      clint_arready <= 1'b1;
      clint_rvalid  <= 1'b0;
    end else if (!clint_rvalid) begin
      clint_arready <= 1'b1;
    end
  end

  // response payload, held until accepted
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      clint_rid <= clint_arid;
      case (offset)
        bus_pkg::mtime_lo_off: begin
          clint_rdata <= mtime.word.lo;
          clint_rresp <= bus_pkg::resp_okay;
        end
        bus_pkg::mtime_hi_off: begin
          clint_rdata <= mtime.word.hi;
          clint_rresp <= bus_pkg::resp_okay;
        end
        default: begin
          clint_rdata <= '0;   // unmapped offset in the window
          clint_rresp <= bus_pkg::resp_slverr;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int id_w   = 4;

  // core-local interruptor window
  localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
  localparam logic [addr_w-1:0] clint_size = 32'h0001_0000; // 64 KiB

  // mtime halves, offsets inside the window
  localparam logic [15:0] mtime_lo_off = 16'hbff8;
  localparam logic [15:0] mtime_hi_off = 16'hbffc;

  // AXI4 response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // single-beat transfers only
  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [2:0] size_word  = 3'b010; // 4 bytes

  // read ids tagged by the arbiter
  localparam logic [id_w-1:0] fetch_id = 4'd0;
  localparam logic [id_w-1:0] lsu_id   = 4'd1;

  // machine timer, seen as one count or as two bus words
  typedef union packed {
    logic [2*data_w-1:0] count;
    struct packed {
      logic [data_w-1:0] hi;
      logic [data_w-1:0] lo;
    } word;
  } mtime_t;

endpackage

`default_nettype wire
